/* Bender.yml */
package:
  name: agc_mem_front

sources:
  - agc_pkg.sv
  - agc_reg_file.sv
  - agc_bank_xlate.sv
  - agc_slot_fsm.sv
  - agc_scaler.sv
  - agc_mem_front.sv
  - target: test
    files:
      - tb_agc_mem_front.sv

/* agc_bank_xlate.sv */
`timescale 1ns/1ps

module agc_bank_xlate (
  input  logic                clk,
  input  logic                rst_l,
  input  agc_pkg::xlate_req_t req,
  input  agc_pkg::bank_t      eb,
  input  agc_pkg::bank_t      fb,
  output agc_pkg::xlate_rsp_t rsp
);
  import agc_pkg::*;

  ram_addr_t ram_off;
  ram_addr_t ram_addr_d;
  ram_addr_t ram_addr_q;
  rom_addr_t rom_off;
  rom_addr_t rom_addr_d;
  rom_addr_t rom_addr_q;
  logic      is_rom_d;
  logic      is_rom_q;
  logic      valid_q;

  // Bank base offsets by table lookup
  always_comb begin
    case (eb)
      3'd0:    ram_off = '0;
      3'd1:    ram_off = ram_bank_size;
      3'd2:    ram_off = ram_addr_t'(2 * ram_bank_size);
      3'd3:    ram_off = ram_addr_t'(3 * ram_bank_size);
      3'd4:    ram_off = ram_addr_t'(4 * ram_bank_size);
      3'd5:    ram_off = ram_addr_t'(5 * ram_bank_size);
      3'd6:    ram_off = ram_addr_t'(6 * ram_bank_size);
      default: ram_off = ram_addr_t'(7 * ram_bank_size);
    endcase
    // ROM bank size equals the window base
    case (fb)
      3'd0:    rom_off = '0;
      3'd1:    rom_off = rom_addr_t'(rom_window_base);
      3'd2:    rom_off = rom_addr_t'(2 * rom_window_base);
      3'd3:    rom_off = rom_addr_t'(3 * rom_window_base);
      3'd4:    rom_off = rom_addr_t'(4 * rom_window_base);
      3'd5:    rom_off = rom_addr_t'(5 * rom_window_base);
      3'd6:    rom_off = rom_addr_t'(6 * rom_window_base);
      default: rom_off = rom_addr_t'(7 * rom_window_base);
    endcase
  end

  // Region classification
  always_comb begin
    is_rom_d   = (req.addr >= rom_window_base);
    ram_addr_d = '0;
    rom_addr_d = '0;
    if (!is_rom_d) begin
      // Fixed erasable maps straight through
      if (req.addr < ram_fixed_top) begin
        ram_addr_d = ram_addr_t'(req.addr);
      end else begin
        ram_addr_d = ram_off + ram_addr_t'(req.addr - ram_fixed_top);
      end
    end else if (req.addr < rom_fixed_base) begin
      // Banked ROM window
      rom_addr_d = rom_off + rom_addr_t'(req.addr - rom_window_base);
    end else begin
      rom_addr_d = rom_addr_t'(req.addr);
    end
  end

  // Response valid one cycle after the strobe
  always_ff @(posedge clk or negedge rst_l) begin
    if (!rst_l) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= req.valid;
    end
  end

  // Result payload loads only on a request
  always_ff @(posedge clk) begin
    if (req.valid) begin
      is_rom_q   <= is_rom_d;
      ram_addr_q <= ram_addr_d;
      rom_addr_q <= rom_addr_d;
    end
  end

  assign rsp = '{valid: valid_q, is_rom: is_rom_q, rom_addr: rom_addr_q, ram_addr: ram_addr_q};

endmodule

/* agc_mem_front.sv */
`timescale 1ns/1ps

module agc_mem_front (
  input  logic                clk,
  input  logic                rst_l,
  input  agc_pkg::reg_wr_t    wr1,
  input  agc_pkg::reg_wr_t    wr2,
  input  agc_pkg::reg_sel_t   rs1_sel,
  input  agc_pkg::reg_sel_t   rs2_sel,
  output agc_pkg::word_t      rs1_data,
  output agc_pkg::word_t      rs2_data,
  input  agc_pkg::xlate_req_t xlate_req,
  output agc_pkg::xlate_rsp_t xlate_rsp,
  input  logic                stall,
  output agc_pkg::slot_en_t   slot_en
);
  import agc_pkg::*;

  // Registered bank numbers into the translator
  bank_t eb;
  bank_t fb;
  // Timer advance strobe
  logic  tick;

  agc_reg_file u_reg_file (
    .clk      (clk),
    .rst_l    (rst_l),
    .wr1      (wr1),
    .wr2      (wr2),
    .rs1_sel  (rs1_sel),
    .rs2_sel  (rs2_sel),
    .tick     (tick),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .eb       (eb),
    .fb       (fb)
  );

  agc_bank_xlate u_bank_xlate (
    .clk   (clk),
    .rst_l (rst_l),
    .req   (xlate_req),
    .eb    (eb),
    .fb    (fb),
    .rsp   (xlate_rsp)
  );

  agc_scaler u_scaler (
    .clk   (clk),
    .rst_l (rst_l),
    .tick  (tick)
  );

  agc_slot_fsm u_slot_fsm (
    .clk     (clk),
    .rst_l   (rst_l),
    .stall   (stall),
    .slot_en (slot_en)
  );

endmodule

/* agc_pkg.sv */
package agc_pkg;

  // Machine word and address widths
  localparam int unsigned word_w     = 15;
  localparam int unsigned addr_w     = 12;
  localparam int unsigned rom_addr_w = 14;
  localparam int unsigned ram_addr_w = 11;
  localparam int unsigned bank_w     = 3;

  typedef logic [word_w-1:0]     word_t;
  typedef logic [addr_w-1:0]     addr_t;
  typedef logic [rom_addr_w-1:0] rom_addr_t;
  typedef logic [ram_addr_w-1:0] ram_addr_t;
  typedef logic [bank_w-1:0]     bank_t;

  // Software address map in octal
  // First banked erasable address
  localparam addr_t ram_fixed_top = 12'o1400;
  // First ROM address and the size of one ROM bank
  localparam addr_t rom_window_base = 12'o2000;
  // Fixed-fixed ROM starts here
  localparam addr_t rom_fixed_base = 12'o4000;
  // Size of one erasable bank
  localparam ram_addr_t ram_bank_size = 11'o400;

  // Clock cycles per timer tick
  localparam int unsigned scaler_div = 8;

  // Central register selects
  typedef enum logic [3:0] {
    reg_a,
    reg_l,
    reg_q,
    reg_eb,
    reg_fb,
    reg_bb,
    reg_zero,
    reg_cyr,
    reg_sr,
    reg_cyl,
    reg_sl,
    reg_time1,
    reg_time2
  } reg_sel_t;

  // One register write port
  typedef struct packed {
    logic     en;
    reg_sel_t sel;
    word_t    data;
  } reg_wr_t;

  // Translation request strobe
  typedef struct packed {
    logic  valid;
    addr_t addr;
  } xlate_req_t;

  // Translation result one cycle after the request
  typedef struct packed {
    logic      valid;
    logic      is_rom;
    rom_addr_t rom_addr;
    ram_addr_t ram_addr;
  } xlate_rsp_t;

  // One-hot instruction slot enables with slot0 in the LSB
  typedef struct packed {
    logic slot3;
    logic slot2;
    logic slot1;
    logic slot0;
  } slot_en_t;

endpackage

/* agc_reg_file.sv */
`timescale 1ns/1ps

module agc_reg_file (
  input  logic              clk,
  input  logic              rst_l,
  input  agc_pkg::reg_wr_t  wr1,
  input  agc_pkg::reg_wr_t  wr2,
  input  agc_pkg::reg_sel_t rs1_sel,
  input  agc_pkg::reg_sel_t rs2_sel,
  input  logic              tick,
  output agc_pkg::word_t    rs1_data,
  output agc_pkg::word_t    rs2_data,
  output agc_pkg::bank_t    eb,
  output agc_pkg::bank_t    fb
);
  import agc_pkg::*;

  // Whole register set where EB and FB together form BB
  typedef struct packed {
    word_t a;
    word_t l;
    word_t q;
    bank_t fb;
    bank_t eb;
    word_t cyr;
    word_t sr;
    word_t cyl;
    word_t sl;
    word_t time1;
    word_t time2;
  } reg_set_t;

  reg_set_t cur;
  reg_set_t nxt;

  // Value a write port stores in read-back format
  function automatic word_t edit_value(reg_wr_t w);
    case (w.sel)
      // Bank fields sit at their BB bit positions
      reg_eb:   return {3'b000, w.data[11:9], 9'b0};
      reg_fb:   return {w.data[14:12], 12'b0};
      reg_bb:   return {w.data[14:9], 9'b0};
      reg_zero: return '0;
      // Editing registers shift on the way in
      reg_cyr:  return {w.data[0], w.data[14:1]};
      reg_sr:   return {w.data[14], w.data[14:1]};
      reg_cyl:  return {w.data[13:0], w.data[14]};
      reg_sl:   return {w.data[13:0], 1'b0};
      default:  return w.data;
    endcase
  endfunction

  // Apply one write port on top of a register set
  function automatic reg_set_t apply_write(reg_set_t r, reg_wr_t w);
    reg_set_t r_n;
    word_t    v;
    r_n = r;
    v   = edit_value(w);
    if (w.en) begin
      case (w.sel)
        reg_a:     r_n.a = v;
        reg_l:     r_n.l = v;
        reg_q:     r_n.q = v;
        reg_eb:    r_n.eb = v[11:9];
        reg_fb:    r_n.fb = v[14:12];
        reg_bb:    {r_n.fb, r_n.eb} = v[14:9];
        reg_cyr:   r_n.cyr = v;
        reg_sr:    r_n.sr = v;
        reg_cyl:   r_n.cyl = v;
        reg_sl:    r_n.sl = v;
        reg_time1: r_n.time1 = v;
        reg_time2: r_n.time2 = v;
        // ZERO and unused codes drop the write
        default:   r_n = r;
      endcase
    end
    return r_n;
  endfunction

  // Stored value in read format
  function automatic word_t stored_word(reg_set_t r, reg_sel_t sel);
    case (sel)
      reg_a:     return r.a;
      reg_l:     return r.l;
      reg_q:     return r.q;
      reg_eb:    return {3'b000, r.eb, 9'b0};
      reg_fb:    return {r.fb, 12'b0};
      reg_bb:    return {r.fb, r.eb, 9'b0};
      reg_cyr:   return r.cyr;
      reg_sr:    return r.sr;
      reg_cyl:   return r.cyl;
      reg_sl:    return r.sl;
      reg_time1: return r.time1;
      reg_time2: return r.time2;
      default:   return '0;
    endcase
  endfunction

  // Read port with forwarding that checks port 2 first
  function automatic word_t read_port(reg_sel_t sel, reg_set_t r, reg_wr_t p1, reg_wr_t p2);
    if (p2.en && (p2.sel == sel)) begin
      return edit_value(p2);
    end
    if (p1.en && (p1.sel == sel)) begin
      return edit_value(p1);
    end
    return stored_word(r, sel);
  endfunction

  always_comb begin
    nxt = cur;
    // Timer advance first so a same-cycle write overrides it
    if (tick) begin
      nxt.time1 = cur.time1 + 1'b1;
      // Carry into TIME2 on TIME1 wrap
      if (&cur.time1) begin
        nxt.time2 = cur.time2 + 1'b1;
      end
    end
    // Port 2 lands last and wins on a collision
    nxt = apply_write(apply_write(nxt, wr1), wr2);
  end

  always_ff @(posedge clk or negedge rst_l) begin
    if (!rst_l) begin
      cur <= '0;
    end else begin
      cur <= nxt;
    end
  end

  assign rs1_data = read_port(rs1_sel, cur, wr1, wr2);
  assign rs2_data = read_port(rs2_sel, cur, wr1, wr2);

  // Registered bank values for translation
  assign eb = cur.eb;
  assign fb = cur.fb;

endmodule

/* agc_scaler.sv */
`timescale 1ns/1ps

module agc_scaler (
  input  logic clk,
  input  logic rst_l,
  output logic tick
);
  import agc_pkg::*;

  localparam int unsigned cnt_w = (scaler_div > 1) ? $clog2(scaler_div) : 1;

  logic [cnt_w-1:0] cnt;
  logic             wrap;

  // Last count before rollover
  assign wrap = (cnt == cnt_w'(scaler_div - 1));

  always_ff @(posedge clk or negedge rst_l) begin
    if (!rst_l) begin
      cnt  <= '0;
      tick <= 1'b0;
    end else begin
      // Free running prescaler
      cnt  <= wrap ? '0 : cnt + 1'b1;
      // One-cycle strobe per period
      tick <= wrap;
    end
  end

endmodule

/* agc_slot_fsm.sv */
`timescale 1ns/1ps

module agc_slot_fsm (
  input  logic              clk,
  input  logic              rst_l,
  input  logic              stall,
  output agc_pkg::slot_en_t slot_en
);
  import agc_pkg::*;

  // State is the count of consecutive stall cycles so far
  typedef enum logic [1:0] {
    st_zero,
    st_one,
    st_two,
    st_three
  } state_t;

  state_t state;
  state_t state_nxt;

  always_ff @(posedge clk or negedge rst_l) begin
    if (!rst_l) begin
      state <= st_zero;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    slot_en   = '0;
    state_nxt = st_zero;
    case (state)
      st_zero: begin
        if (stall) state_nxt = st_one;
        else slot_en.slot0 = 1'b1;
      end
      st_one: begin
        if (stall) state_nxt = st_two;
        else slot_en.slot1 = 1'b1;
      end
      st_two: begin
        if (stall) state_nxt = st_three;
        else slot_en.slot2 = 1'b1;
      end
      // Max depth releases regardless of stall
      default: begin
        slot_en.slot3 = 1'b1;
      end
    endcase
  end

endmodule

/* compile.f */
agc_pkg.sv
agc_reg_file.sv
agc_bank_xlate.sv
agc_slot_fsm.sv
agc_scaler.sv
agc_mem_front.sv
tb_agc_mem_front.sv

/* tb_agc_mem_front.sv */
`timescale 1ns/1ps

module tb_agc_mem_front;
  import agc_pkg::*;

  logic       clk;
  logic       rst_l;
  reg_wr_t    wr1;
  reg_wr_t    wr2;
  reg_sel_t   rs1_sel;
  reg_sel_t   rs2_sel;
  word_t      rs1_data;
  word_t      rs2_data;
  xlate_req_t xlate_req;
  xlate_rsp_t xlate_rsp;
  logic       stall;
  slot_en_t   slot_en;

  int unsigned errors;
  int unsigned checks;
  // Expected bank numbers
  bank_t eb_m;
  bank_t fb_m;

  agc_mem_front dut (
    .clk       (clk),
    .rst_l     (rst_l),
    .wr1       (wr1),
    .wr2       (wr2),
    .rs1_sel   (rs1_sel),
    .rs2_sel   (rs2_sel),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data),
    .xlate_req (xlate_req),
    .xlate_rsp (xlate_rsp),
    .stall     (stall),
    .slot_en   (slot_en)
  );

  // 4 ns clock
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Read-back value of a write from the edit and mask rules
  function automatic word_t stored_form(reg_sel_t sel, word_t d);
    case (sel)
      reg_eb:   return d & 15'o07000;
      reg_fb:   return d & 15'o70000;
      reg_bb:   return d & 15'o77000;
      reg_zero: return '0;
      reg_cyr:  return (d >> 1) | (d << 14);
      // Sign bit stays and also shifts down
      reg_sr:   return (d >> 1) | (d & 15'h4000);
      reg_cyl:  return (d << 1) | (d >> 14);
      reg_sl:   return d << 1;
      default:  return d;
    endcase
  endfunction

  // Expected translation from the region rules
  function automatic xlate_rsp_t xlate_model(addr_t a, bank_t e, bank_t f);
    xlate_rsp_t r;
    r = '0;
    r.valid = 1'b1;
    if (a < rom_window_base) begin
      if (a < ram_fixed_top) begin
        r.ram_addr = a;
      end else begin
        r.ram_addr = e * ram_bank_size + (a - ram_fixed_top);
      end
    end else begin
      r.is_rom = 1'b1;
      if (a < rom_fixed_base) begin
        r.rom_addr = f * rom_window_base + (a - rom_window_base);
      end else begin
        r.rom_addr = a;
      end
    end
    return r;
  endfunction

  task automatic check_value(string name, logic [31:0] exp, logic [31:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  // Write through port 1 and check the forwarded then the stored value
  task automatic write_and_check(string name, reg_sel_t sel, word_t data);
    word_t exp;
    exp = stored_form(sel, data);
    @(posedge clk);
    wr1     <= '{en: 1'b1, sel: sel, data: data};
    rs1_sel <= sel;
    @(negedge clk);
    check_value({name, " fwd"}, exp, rs1_data);
    @(posedge clk);
    wr1 <= '0;
    @(negedge clk);
    check_value({name, " stored"}, exp, rs1_data);
  endtask

  task automatic check_banks(string name);
    @(posedge clk);
    rs1_sel <= reg_eb;
    rs2_sel <= reg_fb;
    @(negedge clk);
    check_value({name, " EB"}, {3'b000, eb_m, 9'b0}, rs1_data);
    check_value({name, " FB"}, {fb_m, 12'b0}, rs2_data);
    @(posedge clk);
    rs1_sel <= reg_bb;
    @(negedge clk);
    check_value({name, " BB"}, {fb_m, eb_m, 9'b0}, rs1_data);
  endtask

  task automatic test_basic();
    word_t d1;
    word_t d2;
    repeat (4) begin
      write_and_check("basic A", reg_a, word_t'($urandom));
      write_and_check("basic L", reg_l, word_t'($urandom));
      write_and_check("basic Q", reg_q, word_t'($urandom));
    end
    // ZERO ignores writes
    write_and_check("basic ZERO", reg_zero, 15'h7fff);
    d1 = word_t'($urandom);
    d2 = word_t'($urandom);
    @(posedge clk);
    wr1     <= '{en: 1'b1, sel: reg_q, data: d1};
    wr2     <= '{en: 1'b1, sel: reg_q, data: d2};
    rs2_sel <= reg_q;
    @(negedge clk);
    check_value("basic both ports fwd", d2, rs2_data);
    @(posedge clk);
    wr1 <= '0;
    wr2 <= '0;
    @(negedge clk);
    check_value("basic both ports", d2, rs2_data);
  endtask

  task automatic test_editing();
    repeat (4) begin
      write_and_check("editing CYR", reg_cyr, word_t'($urandom));
      write_and_check("editing SR", reg_sr, word_t'($urandom));
      write_and_check("editing CYL", reg_cyl, word_t'($urandom));
      write_and_check("editing SL", reg_sl, word_t'($urandom));
    end
  endtask

  task automatic test_banks();
    word_t d;
    repeat (3) begin
      d = word_t'($urandom);
      write_and_check("bank EB", reg_eb, d);
      eb_m = d[11:9];
      check_banks("bank after EB");
      d = word_t'($urandom);
      write_and_check("bank FB", reg_fb, d);
      fb_m = d[14:12];
      check_banks("bank after FB");
      d = word_t'($urandom);
      write_and_check("bank BB", reg_bb, d);
      eb_m = d[11:9];
      fb_m = d[14:12];
      check_banks("bank after BB");
    end
  endtask

  // Back-to-back strobes with each response one cycle later
  task automatic test_xlate();
    xlate_rsp_t  exp_q[$];
    addr_t       a;
    word_t       d;
    int unsigned n;
    n = 24;
    d = word_t'($urandom);
    write_and_check("xlate set BB", reg_bb, d);
    eb_m = d[11:9];
    fb_m = d[14:12];
    for (int i = 0; i <= n; i++) begin
      @(posedge clk);
      if (i < n) begin
        // Cycle through the four regions
        case (i % 4)
          0:       a = addr_t'($urandom_range(12'o1377, 0));
          1:       a = addr_t'($urandom_range(12'o1777, 12'o1400));
          2:       a = addr_t'($urandom_range(12'o3777, 12'o2000));
          default: a = addr_t'($urandom_range(12'o7777, 12'o4000));
        endcase
        xlate_req <= '{valid: 1'b1, addr: a};
        exp_q.push_back(xlate_model(a, eb_m, fb_m));
      end else begin
        xlate_req <= '0;
      end
      @(negedge clk);
      if (i == 0) begin
        check_value("xlate idle valid", 0, xlate_rsp.valid);
      end else begin
        check_value("xlate rsp", exp_q.pop_front(), xlate_rsp);
      end
    end
    @(negedge clk);
    check_value("xlate valid drop", 0, xlate_rsp.valid);
  endtask

  task automatic test_timers();
    word_t t2;
    int    cycles;
    t2 = word_t'($urandom);
    @(posedge clk);
    wr1     <= '{en: 1'b1, sel: reg_time1, data: 15'h7fff};
    wr2     <= '{en: 1'b1, sel: reg_time2, data: t2};
    rs1_sel <= reg_time1;
    rs2_sel <= reg_time2;
    @(posedge clk);
    wr1 <= '0;
    wr2 <= '0;
    cycles = 0;
    @(negedge clk);
    // Next tick wraps TIME1
    while ((rs1_data !== '0) && (cycles < 4 * scaler_div)) begin
      @(negedge clk);
      cycles++;
    end
    if (rs1_data !== '0) begin
      errors++;
      $display("ERROR: timers test timed out waiting for TIME1 to wrap to zero");
    end else begin
      check_value("timers TIME2 carry", word_t'(t2 + 1'b1), rs2_data);
    end
  endtask

  task automatic test_stall();
    int       depth;
    slot_en_t exp;
    depth = 0;
    for (int run = 0; run <= 4; run++) begin
      // Stall for run cycles and release for one
      for (int c = 0; c <= run; c++) begin
        @(posedge clk);
        stall <= (c < run);
        @(negedge clk);
        exp = '0;
        if (depth == 3) begin
          exp.slot3 = 1'b1;
          depth = 0;
        end else if (stall) begin
          depth++;
        end else begin
          exp   = slot_en_t'(4'b0001 << depth);
          depth = 0;
        end
        check_value($sformatf("stall run %0d cycle %0d", run, c), exp, slot_en);
      end
    end
  endtask

  initial begin
    void'($urandom(32'h1723_64e6));
    errors    = 0;
    checks    = 0;
    eb_m      = '0;
    fb_m      = '0;
    rst_l     = 1'b0;
    wr1       = '0;
    wr2       = '0;
    rs1_sel   = reg_a;
    rs2_sel   = reg_a;
    xlate_req = '0;
    stall     = 1'b0;
    repeat (8) @(posedge clk);
    rst_l <= 1'b1;
    test_basic();
    test_editing();
    test_banks();
    test_xlate();
    test_timers();
    test_stall();
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule
